//--- Makefile
VERILATOR := verilator
TOP       := pease_fft_tb
FILELIST  := pease_fft.f
LINTFLAGS := --lint-only --timing
SIMFLAGS  := --binary --timing
BUILD_DIR := obj_dir
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/butterfly_array.sv
`timescale 1ns/10ps

module butterfly_array (
  input  fft_pkg::complex_t bf_in[fft_pkg::N_SAMPLES],
  input  fft_pkg::sample_t  tw_re[fft_pkg::HALF_N],
  input  fft_pkg::sample_t  tw_im[fft_pkg::HALF_N],
  output fft_pkg::complex_t bf_out[fft_pkg::N_SAMPLES]
);
  import fft_pkg::*;

  // full-width product, then back to the sample format by truncation
  function automatic sample_t mul_fx(input sample_t x, input sample_t y);
    logic signed [2*SAMPLE_W-1:0] p;
    p = x * y;
    return sample_t'(p >>> FRAC_BITS);
  endfunction

  for (genvar j = 0; j < HALF_N; j++) begin : g_bf
    sample_t a_re;
    sample_t a_im;
    sample_t b_re;
    sample_t b_im;
    sample_t t_re;
    sample_t t_im;
    sample_t sum_re;
    sample_t sum_im;
    sample_t dif_re;
    sample_t dif_im;

    assign a_re = sample_t'(bf_in[2*j][SAMPLE_W-1:0]);
    assign a_im = sample_t'(bf_in[2*j][2*SAMPLE_W-1:SAMPLE_W]);
    assign b_re = sample_t'(bf_in[2*j+1][SAMPLE_W-1:0]);
    assign b_im = sample_t'(bf_in[2*j+1][2*SAMPLE_W-1:SAMPLE_W]);

    // t = w * b
    assign t_re = mul_fx(b_re, tw_re[j]) - mul_fx(b_im, tw_im[j]);
    assign t_im = mul_fx(b_re, tw_im[j]) + mul_fx(b_im, tw_re[j]);

    // sums wrap, no saturation
    assign sum_re = a_re + t_re;
    assign sum_im = a_im + t_im;
    assign dif_re = a_re - t_re;
    assign dif_im = a_im - t_im;

    assign bf_out[2*j]   = {sum_im, sum_re};
    assign bf_out[2*j+1] = {dif_im, dif_re};
  end

endmodule

//--- hw/fft_pkg.sv
package fft_pkg;

  // frame geometry
  localparam int N_SAMPLES = 8;
  localparam int HALF_N    = N_SAMPLES / 2;
  localparam int LOG_N     = $clog2(N_SAMPLES);
  localparam int STAGE_W   = (LOG_N > 1) ? $clog2(LOG_N) : 1;

  // fixed-point format, Q15.16
  localparam int SAMPLE_W  = 32;
  localparam int FRAC_BITS = 16;

  localparam real PI = 3.14159265358979323846;

  // one real or imaginary value
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // imaginary part in the upper half, real part in the lower half
  typedef logic [2*SAMPLE_W-1:0] complex_t;

  typedef logic [STAGE_W-1:0] stage_t;
  typedef logic [LOG_N-1:0]   index_t;

  typedef enum logic [1:0] {
    idle,
    compute,
    done
  } core_state_t;

endpackage

//--- hw/pease_fft.sv
`timescale 1ns/10ps

module pease_fft (
  input  logic             clk,
  input  logic             reset,
  input  fft_pkg::sample_t in_data,
  input  logic             in_valid,
  output logic             in_ready,
  output fft_pkg::sample_t out_data,
  output logic             out_valid,
  input  logic             out_ready
);
  import fft_pkg::*;

  // deserializer to core
  sample_t frame_in[N_SAMPLES];
  logic    frame_in_valid;
  logic    frame_in_ready;

  // core to serializer
  sample_t frame_out[N_SAMPLES];
  logic    frame_out_valid;
  logic    frame_out_ready;

  sample_deserializer u_deser (
    .clk            (clk),
    .reset          (reset),
    .in_data        (in_data),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .frame_in       (frame_in),
    .frame_in_valid (frame_in_valid),
    .frame_in_ready (frame_in_ready)
  );

  pease_fft_core u_core (
    .clk             (clk),
    .reset           (reset),
    .frame_in        (frame_in),
    .frame_in_valid  (frame_in_valid),
    .frame_in_ready  (frame_in_ready),
    .frame_out       (frame_out),
    .frame_out_valid (frame_out_valid),
    .frame_out_ready (frame_out_ready)
  );

  sample_serializer u_ser (
    .clk             (clk),
    .reset           (reset),
    .frame_out       (frame_out),
    .frame_out_valid (frame_out_valid),
    .frame_out_ready (frame_out_ready),
    .out_data        (out_data),
    .out_valid       (out_valid),
    .out_ready       (out_ready)
  );

endmodule

//--- hw/pease_fft_core.sv
`timescale 1ns/10ps

module pease_fft_core (
  input  logic             clk,
  input  logic             reset,
  input  fft_pkg::sample_t frame_in[fft_pkg::N_SAMPLES],
  input  logic             frame_in_valid,
  output logic             frame_in_ready,
  output fft_pkg::sample_t frame_out[fft_pkg::N_SAMPLES],
  output logic             frame_out_valid,
  input  logic             frame_out_ready
);
  import fft_pkg::*;

  core_state_t state;
  stage_t      stage;
  logic        capture;

  complex_t frame_q[N_SAMPLES];
  complex_t bf_out[N_SAMPLES];
  complex_t shuffled[N_SAMPLES];
  sample_t  tw_re[HALF_N];
  sample_t  tw_im[HALF_N];

  function automatic index_t bit_rev(input index_t i);
    index_t r;
    for (int b = 0; b < LOG_N; b++) begin
      r[b] = i[LOG_N-1-b];
    end
    return r;
  endfunction

  // one-bit left rotation of the slot index
  function automatic index_t rot_left(input index_t i);
    return {i[LOG_N-2:0], i[LOG_N-1]};
  endfunction

  assign frame_in_ready  = (state == idle);
  assign frame_out_valid = (state == done);
  assign capture         = frame_in_valid && frame_in_ready;

  twiddle_rom u_twiddle_rom (
    .stage (stage),
    .tw_re (tw_re),
    .tw_im (tw_im)
  );

  butterfly_array u_butterfly_array (
    .bf_in  (frame_q),
    .tw_re  (tw_re),
    .tw_im  (tw_im),
    .bf_out (bf_out)
  );

  // perfect shuffle between passes
  for (genvar i = 0; i < N_SAMPLES; i++) begin : g_shuffle
    assign shuffled[i]  = bf_out[rot_left(index_t'(i))];
    assign frame_out[i] = sample_t'(frame_q[i][SAMPLE_W-1:0]);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      stage <= '0;
    end else begin
      case (state)
        idle: begin
          if (capture) begin
            state <= compute;
            stage <= '0;
          end
        end
        compute: begin
          // one pass per cycle
          if (stage == stage_t'(LOG_N - 1)) begin
            state <= done;
            stage <= '0;
          end else begin
            stage <= stage + 1'b1;
          end
        end
        done: begin
          if (frame_out_ready) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // frame register, bit-reversed real input on capture
  always_ff @(posedge clk) begin
    if (capture) begin
      for (int i = 0; i < N_SAMPLES; i++) begin
        frame_q[i] <= {{SAMPLE_W{1'b0}}, frame_in[bit_rev(index_t'(i))]};
      end
    end else if (state == compute) begin
      for (int i = 0; i < N_SAMPLES; i++) begin
        frame_q[i] <= shuffled[i];
      end
    end
  end

endmodule

//--- hw/sample_deserializer.sv
`timescale 1ns/10ps

module sample_deserializer (
  input  logic             clk,
  input  logic             reset,
  input  fft_pkg::sample_t in_data,
  input  logic             in_valid,
  output logic             in_ready,
  output fft_pkg::sample_t frame_in[fft_pkg::N_SAMPLES],
  output logic             frame_in_valid,
  input  logic             frame_in_ready
);
  import fft_pkg::*;

  index_t wr_idx;
  logic   full;
  logic   accept;

  // input blocked while a full frame waits for the core
  assign in_ready       = !full;
  assign accept         = in_valid && in_ready;
  assign frame_in_valid = full;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_idx <= '0;
      full   <= 1'b0;
    end else begin
      if (accept) begin
        if (wr_idx == index_t'(N_SAMPLES - 1)) begin
          wr_idx <= '0;
          full   <= 1'b1;
        end else begin
          wr_idx <= wr_idx + 1'b1;
        end
      end else if (full && frame_in_ready) begin
        full <= 1'b0;
      end
    end
  end

  // sample slots
  always_ff @(posedge clk) begin
    if (accept) begin
      frame_in[wr_idx] <= in_data;
    end
  end

endmodule

//--- hw/sample_serializer.sv
`timescale 1ns/10ps

module sample_serializer (
  input  logic             clk,
  input  logic             reset,
  input  fft_pkg::sample_t frame_out[fft_pkg::N_SAMPLES],
  input  logic             frame_out_valid,
  output logic             frame_out_ready,
  output fft_pkg::sample_t out_data,
  output logic             out_valid,
  input  logic             out_ready
);
  import fft_pkg::*;

  sample_t frame_q[N_SAMPLES];
  index_t  rd_idx;
  logic    busy;
  logic    load;

  assign frame_out_ready = !busy;
  assign load            = frame_out_valid && frame_out_ready;
  assign out_valid       = busy;
  assign out_data        = frame_q[rd_idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      busy   <= 1'b0;
      rd_idx <= '0;
    end else begin
      if (load) begin
        busy   <= 1'b1;
        rd_idx <= '0;
      end else if (out_valid && out_ready) begin
        // last word frees the buffer for the next frame
        if (rd_idx == index_t'(N_SAMPLES - 1)) begin
          busy   <= 1'b0;
          rd_idx <= '0;
        end else begin
          rd_idx <= rd_idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      for (int i = 0; i < N_SAMPLES; i++) begin
        frame_q[i] <= frame_out[i];
      end
    end
  end

endmodule

//--- hw/twiddle_rom.sv
`timescale 1ns/10ps

module twiddle_rom (
  input  fft_pkg::stage_t  stage,
  output fft_pkg::sample_t tw_re[fft_pkg::HALF_N],
  output fft_pkg::sample_t tw_im[fft_pkg::HALF_N]
);
  import fft_pkg::*;

  sample_t cos_tab[HALF_N];
  sample_t sin_tab[HALF_N];
  stage_t  shift;
  index_t  mask;

  // round to the nearest lsb of the fixed-point grid
  function automatic sample_t to_fixed(input real x);
    return sample_t'(int'(x * (2.0 ** FRAC_BITS)));
  endfunction

  // cos(2*pi*k/N) and -sin(2*pi*k/N), only the first half is needed
  for (genvar k = 0; k < HALF_N; k++) begin : g_tab
    assign cos_tab[k] = to_fixed($cos(2.0 * PI * k / N_SAMPLES));
    assign sin_tab[k] = to_fixed(-$sin(2.0 * PI * k / N_SAMPLES));
  end

  // early stages use coarser exponents, stage 0 is all ones
  assign shift = stage_t'(LOG_N - 1) - stage;
  assign mask  = {LOG_N{1'b1}} << shift;

  for (genvar j = 0; j < HALF_N; j++) begin : g_sel
    index_t e;

    assign e        = index_t'(j) & mask;
    assign tw_re[j] = cos_tab[e[LOG_N-2:0]];
    assign tw_im[j] = sin_tab[e[LOG_N-2:0]];
  end

endmodule

//--- pease_fft.f
hw/fft_pkg.sv
hw/sample_deserializer.sv
hw/sample_serializer.sv
hw/twiddle_rom.sv
hw/butterfly_array.sv
hw/pease_fft_core.sv
hw/pease_fft.sv
tests/pease_fft_tb.sv

//--- tests/pease_fft_tb.sv
`timescale 1ns/10ps

module pease_fft_tb;
  import fft_pkg::*;

  localparam int      N_FRAMES_TOTAL  = 11;
  localparam int      WATCHDOG_CYCLES = N_FRAMES_TOTAL * 4000 + 500;
  localparam real     TWO_PI          = 6.283185307179586;
  localparam sample_t ONE             = 32'sh0001_0000;

  logic    clk;
  logic    reset;
  sample_t in_data;
  logic    in_valid;
  logic    in_ready;
  sample_t out_data;
  logic    out_valid;
  logic    out_ready = 1'b0;

  int      seed = 34444;
  int      bp_rnd;
  logic    bp_enable = 1'b0;
  int      mismatch_count = 0;
  int      other_count = 0;
  int      recv_count = 0;
  string   cur_test = "reset";
  sample_t exp_q[$];
  sample_t burst[8][N_SAMPLES];

  pease_fft uut (
    .clk       (clk),
    .reset     (reset),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the output stream stopped before all expected words arrived");
    $display("TEST FAILED");
    $finish;
  end

  // sink back-pressure
  always @(posedge clk) begin
    if (bp_enable) begin
      bp_rnd = $random(seed);
      out_ready <= bp_rnd[0];
    end else begin
      out_ready <= 1'b1;
    end
  end

  // a word transfers on the next rising edge
  always @(negedge clk) begin
    if (!reset && out_valid && out_ready) begin
      recv_count++;
      if (exp_q.size() == 0) begin
        other_count++;
        $display("%s: output word %h arrived with nothing expected", cur_test, out_data);
      end else begin
        compare_sample(cur_test, exp_q.pop_front(), out_data);
      end
    end
  end

  task automatic compare_sample(input string name, input sample_t expected,
                                input sample_t actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("mismatch %s: expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic compare_count(input string name, input int expected, input int actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("mismatch %s: expected %0d words actual %0d", name, expected, actual);
    end
  endtask

  task automatic compare_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("mismatch %s: expected %b actual %b", name, expected, actual);
    end
  endtask

  // nearest multiple of 2^-16
  function automatic sample_t to_q16(input real x);
    return sample_t'($rtoi(x * 65536.0 + ((x < 0.0) ? -0.5 : 0.5)));
  endfunction

  function automatic sample_t fixed_mul(input sample_t x, input sample_t y);
    logic [63:0] p;
    p = {{32{x[31]}}, x} * {{32{y[31]}}, y};
    return p[47:16];
  endfunction

  // reference transform, pushes the real outputs of one frame
  function automatic void expect_model(input sample_t frame[N_SAMPLES]);
    sample_t re[N_SAMPLES];
    sample_t im[N_SAMPLES];
    sample_t bf_re[N_SAMPLES];
    sample_t bf_im[N_SAMPLES];
    sample_t w_re;
    sample_t w_im;
    sample_t t_re;
    sample_t t_im;
    int      rev;
    int      low;
    int      e;
    int      src;
    for (int i = 0; i < N_SAMPLES; i++) begin
      rev = 0;
      for (int b = 0; b < LOG_N; b++)
        rev = rev | (((i >> b) & 1) << (LOG_N - 1 - b));
      re[i] = frame[rev];
      im[i] = '0;
    end
    for (int s = 0; s < LOG_N; s++) begin
      low = LOG_N - 1 - s;
      for (int j = 0; j < HALF_N; j++) begin
        // butterfly number with its low bits cleared
        e    = (j >> low) << low;
        w_re = to_q16($cos(TWO_PI * e / N_SAMPLES));
        w_im = to_q16(-$sin(TWO_PI * e / N_SAMPLES));
        t_re = fixed_mul(re[2*j+1], w_re) - fixed_mul(im[2*j+1], w_im);
        t_im = fixed_mul(re[2*j+1], w_im) + fixed_mul(im[2*j+1], w_re);
        bf_re[2*j]   = re[2*j] + t_re;
        bf_im[2*j]   = im[2*j] + t_im;
        bf_re[2*j+1] = re[2*j] - t_re;
        bf_im[2*j+1] = im[2*j] - t_im;
      end
      // slot i takes the output at the left rotation of i
      for (int i = 0; i < N_SAMPLES; i++) begin
        src   = ((i << 1) | (i >> (LOG_N - 1))) & (N_SAMPLES - 1);
        re[i] = bf_re[src];
        im[i] = bf_im[src];
      end
    end
    for (int i = 0; i < N_SAMPLES; i++)
      exp_q.push_back(re[i]);
  endfunction

  // starts right after a rising edge
  task automatic send_word(input sample_t value);
    logic accepted;
    in_data  <= value;
    in_valid <= 1'b1;
    do begin
      @(negedge clk);
      accepted = in_ready;
      @(posedge clk);
    end while (!accepted);
  endtask

  task automatic run_burst(input string name, input int n_frames, input logic stall);
    int start;
    cur_test = name;
    start    = recv_count;
    if (stall) begin
      @(negedge clk);
      bp_enable = 1'b1;
      @(posedge clk);
    end
    for (int f = 0; f < n_frames; f++) begin
      for (int i = 0; i < N_SAMPLES; i++)
        send_word(burst[f][i]);
    end
    in_valid <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    repeat (2 * N_SAMPLES) @(posedge clk);
    @(negedge clk);
    bp_enable = 1'b0;
    @(posedge clk);
    compare_count(name, n_frames * N_SAMPLES, recv_count - start);
  endtask

  task automatic fill_random(input int n_frames);
    for (int f = 0; f < n_frames; f++) begin
      for (int i = 0; i < N_SAMPLES; i++)
        burst[f][i] = $random(seed) % (8 << FRAC_BITS);
      expect_model(burst[f]);
    end
  endtask

  task automatic impulse_frame();
    for (int i = 0; i < N_SAMPLES; i++) begin
      burst[0][i] = (i == 0) ? ONE : '0;
      // flat spectrum
      exp_q.push_back(ONE);
    end
    run_burst("impulse", 1, 1'b0);
  endtask

  task automatic constant_frame();
    sample_t a;
    a = 32'sh0002_4000;
    for (int i = 0; i < N_SAMPLES; i++) begin
      burst[0][i] = a;
      // everything lands in the dc bin
      exp_q.push_back((i == 0) ? sample_t'(N_SAMPLES * a) : '0);
    end
    run_burst("constant", 1, 1'b0);
  endtask

  task automatic alternating_frame();
    sample_t a;
    a = 32'sh0001_8000;
    for (int i = 0; i < N_SAMPLES; i++) begin
      burst[0][i] = (i % 2 == 0) ? a : -a;
      // everything lands in the nyquist bin
      exp_q.push_back((i == HALF_N) ? sample_t'(N_SAMPLES * a) : '0);
    end
    run_burst("alternating", 1, 1'b0);
  endtask

  task automatic random_frames();
    fill_random(5);
    run_burst("random", 5, 1'b0);
  endtask

  task automatic back_to_back_frames();
    fill_random(3);
    run_burst("back_to_back", 3, 1'b1);
  endtask

  initial begin
    reset    <= 1'b1;
    in_data  <= '0;
    in_valid <= 1'b0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    compare_flag("reset in_ready", 1'b1, in_ready);
    compare_flag("reset out_valid", 1'b0, out_valid);
    @(posedge clk);
    impulse_frame();
    constant_frame();
    alternating_frame();
    random_frames();
    back_to_back_frames();
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count + other_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
